// File: Makefile
# Verilator flow for the wishbone memory subsystem
VERILATOR ?= verilator
TOP       ?= wb_mem_subsys_tb
FILELIST  ?= wb_mem_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench prints its pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_clk_gen.sv
// clock and reset source for the subsystem testbench
// 40 ns clock, reset held low for the first four rising edges
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a rising edge like any other driven input
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: bench/wb_mem_subsys_chk.sv
// handshake assertions bound into the wishbone bridge
// ack qualification, command hold, response latency and reset behavior
`timescale 1ns/10ps
`include "wb_bridge_cfg.svh"

module wb_mem_subsys_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic cmd_v_i,
  input logic cmd_ready_and_i,
  input logic resp_v_i
);

  // ack belongs to an active strobe
  ack_with_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("acknowledge seen without an active strobe");

  // a stalled command stays offered
  cmd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_v_i && !cmd_ready_and_i) |=> cmd_v_i)
    else $error("command valid dropped before it was accepted");

  // every accepted command is answered after the client latency
  resp_after_cmd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cmd_v_i && cmd_ready_and_i) |-> ##(`MEM_RESP_LATENCY) resp_v_i)
    else $error("no response followed an accepted command");

  ack_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_ack_i)
    else $error("acknowledge seen during reset");

endmodule

// File: bench/wb_mem_subsys_tb.sv
// directed testbench for the wishbone memory subsystem
// runs each test task in turn, keeps a reference memory and prints a summary
`timescale 1ns/10ps
`include "wb_bridge_cfg.svh"

module wb_mem_subsys_tb;

  localparam int ACK_TIMEOUT = 20;
  localparam int IDX_W       = $clog2(`MEM_WORDS);

  logic             clk;
  logic             arst_n;
  wb_pkg::wb_adr_t  wb_adr;
  wb_pkg::wb_data_t wb_dat_wr;
  wb_pkg::wb_data_t wb_dat_rd;
  logic             wb_cyc;
  logic             wb_stb;
  wb_pkg::wb_sel_t  wb_sel;
  logic             wb_we;
  logic             wb_ack;

  wb_pkg::wb_data_t model_mem [`MEM_WORDS];
  logic [31:0]      lfsr_q = 32'd87910;
  wb_pkg::wb_data_t last_rdata;
  int               last_ack_cycle;
  int               last_ack_count;
  int               err_count;
  int               tests_run;
  int               tests_failed;

  tb_clk_gen tb_clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  wb_mem_subsys wb_mem_subsys_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_wr),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_dat_o (wb_dat_rd),
    .wb_ack_o (wb_ack)
  );

  bind wb_client_bridge wb_mem_subsys_chk wb_mem_subsys_chk_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_ack_i        (wb_ack_o),
    .cmd_v_i         (msg.cmd_v),
    .cmd_ready_and_i (msg.cmd_ready_and),
    .resp_v_i        (msg.resp_v)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_bit()};
    end
    return val;
  endfunction

  // bytes written for a select with odd patterns taking the full word
  function automatic int sel_bytes(input wb_pkg::wb_sel_t sel);
    case (sel)
      8'h01:   return 1;
      8'h03:   return 2;
      8'h0f:   return 4;
      default: return `WB_SEL_WIDTH;
    endcase
  endfunction

  function automatic void model_write(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_data_t dat,
                                      input wb_pkg::wb_sel_t sel);
    int idx;
    idx = int'(adr) % `MEM_WORDS;
    for (int b = 0; b < sel_bytes(sel); b++) begin
      model_mem[idx][8*b +: 8] = dat[8*b +: 8];
    end
  endfunction

  function automatic wb_pkg::wb_data_t model_word(input wb_pkg::wb_adr_t adr);
    return model_mem[int'(adr) % `MEM_WORDS];
  endfunction

  // one classic access and its idle gap with stb low, acks counted throughout
  task automatic bus_access(input string name, input logic we, input wb_pkg::wb_adr_t adr,
                            input wb_pkg::wb_data_t dat, input wb_pkg::wb_sel_t sel,
                            input int idle);
    int   cycle;
    logic got;
    cycle          = 0;
    got            = 1'b0;
    last_ack_cycle = -1;
    last_ack_count = 0;
    @(posedge clk);
    wb_cyc    <= 1'b1;
    wb_stb    <= 1'b1;
    wb_we     <= we;
    wb_adr    <= adr;
    wb_dat_wr <= dat;
    wb_sel    <= sel;
    while (!got && (cycle < ACK_TIMEOUT)) begin
      @(negedge clk);
      if (wb_ack) begin
        got            = 1'b1;
        last_ack_cycle = cycle;
        last_ack_count = 1;
        last_rdata     = wb_dat_rd;
      end else begin
        cycle++;
      end
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!got) begin
      $display("%s: no acknowledge came within %0d cycles", name, ACK_TIMEOUT);
      err_count++;
    end
    if (we) begin
      model_write(adr, dat, sel);
    end
    for (int i = 0; i < idle; i++) begin
      @(negedge clk);
      if (wb_ack) begin
        last_ack_count++;
      end
    end
  endtask

  task automatic check_data(input string name, input wb_pkg::wb_data_t exp,
                            input wb_pkg::wb_data_t act);
    if (act !== exp) begin
      $display("Mismatch %s data: expected %h actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_ack_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Mismatch %s ack cycles: expected %0d actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  task automatic close_test(input string name, input int start_errs);
    tests_run++;
    if (err_count == start_errs) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_count - start_errs);
    end
  endtask

  task automatic reset_state();
    int start_errs;
    start_errs = err_count;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      if (wb_ack) begin
        $display("reset_state: acknowledge seen while stb is low");
        err_count++;
      end
    end
    for (int w = 0; w < `MEM_WORDS; w++) begin
      bus_access("reset_state", 1'b0, wb_pkg::wb_adr_t'(w), '0, 8'hff, 1);
      check_data("reset_state", '0, last_rdata);
    end
    close_test("reset_state", start_errs);
  endtask

  task automatic full_word_round_trip();
    int              start_errs;
    wb_pkg::wb_adr_t adr;
    start_errs = err_count;
    for (int i = 0; i < 4; i++) begin
      adr = wb_pkg::wb_adr_t'(rand_bits(`WB_ADDR_WIDTH));
      bus_access("full_word_round_trip", 1'b1, adr, rand_bits(`WB_DATA_WIDTH), 8'hff, 2);
      check_ack_cycles("full_word_round_trip", 0, last_ack_cycle);
      bus_access("full_word_round_trip", 1'b0, adr, '0, 8'hff, 1);
      check_ack_cycles("full_word_round_trip", 2, last_ack_cycle);
      check_data("full_word_round_trip", model_word(adr), last_rdata);
    end
    close_test("full_word_round_trip", start_errs);
  endtask

  task automatic narrow_writes();
    int              start_errs;
    wb_pkg::wb_adr_t adr;
    wb_pkg::wb_sel_t sels [3];
    start_errs = err_count;
    sels       = '{8'h01, 8'h03, 8'h0f};
    for (int i = 0; i < 3; i++) begin
      adr = wb_pkg::wb_adr_t'(rand_bits(IDX_W));
      // preset the whole word, then overwrite its low bytes
      bus_access("narrow_writes", 1'b1, adr, rand_bits(`WB_DATA_WIDTH), 8'hff, 2);
      bus_access("narrow_writes", 1'b1, adr, rand_bits(`WB_DATA_WIDTH), sels[i], 2);
      check_ack_cycles("narrow_writes", 0, last_ack_cycle);
      bus_access("narrow_writes", 1'b0, adr, '0, 8'hff, 1);
      check_data("narrow_writes", model_word(adr), last_rdata);
    end
    close_test("narrow_writes", start_errs);
  endtask

  task automatic address_wrap();
    int              start_errs;
    int              idx;
    int              hi;
    wb_pkg::wb_adr_t alias_adr;
    start_errs = err_count;
    for (int i = 0; i < 4; i++) begin
      idx       = int'(rand_bits(IDX_W));
      hi        = int'(rand_bits(`WB_ADDR_WIDTH - IDX_W)) | 1;
      alias_adr = wb_pkg::wb_adr_t'(hi * `MEM_WORDS + idx);
      bus_access("address_wrap", 1'b1, alias_adr, rand_bits(`WB_DATA_WIDTH), 8'hff, 2);
      bus_access("address_wrap", 1'b0, wb_pkg::wb_adr_t'(idx), '0, 8'hff, 1);
      check_data("address_wrap", model_word(wb_pkg::wb_adr_t'(idx)), last_rdata);
    end
    close_test("address_wrap", start_errs);
  endtask

  task automatic back_to_back_mix();
    int              start_errs;
    int              idle;
    logic            is_wr;
    wb_pkg::wb_adr_t adr;
    wb_pkg::wb_sel_t sel_pick [8];
    start_errs = err_count;
    sel_pick   = '{8'h01, 8'h03, 8'h0f, 8'hff, 8'hf0, 8'h3c, 8'h80, 8'hff};
    for (int i = 0; i < 24; i++) begin
      is_wr = lfsr_bit();
      adr   = wb_pkg::wb_adr_t'(rand_bits(`WB_ADDR_WIDTH));
      idle  = 1 + int'(rand_bits(2));
      if (is_wr) begin
        bus_access("back_to_back_mix", 1'b1, adr, rand_bits(`WB_DATA_WIDTH),
                   sel_pick[int'(rand_bits(3))], idle);
      end else begin
        bus_access("back_to_back_mix", 1'b0, adr, '0, 8'hff, idle);
        check_data("back_to_back_mix", model_word(adr), last_rdata);
      end
      check_ack_cycles("back_to_back_mix", 1, last_ack_count);
    end
    close_test("back_to_back_mix", start_errs);
  endtask

  initial begin
    int wait_cycles;
    wb_adr       = '0;
    wb_dat_wr    = '0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_sel       = '0;
    wb_we        = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    wait_cycles  = 0;
    for (int w = 0; w < `MEM_WORDS; w++) begin
      model_mem[w] = '0;
    end
    while ((arst_n !== 1'b1) && (wait_cycles < ACK_TIMEOUT)) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset was never released");
      err_count++;
    end
    // bridge spends one cycle in its reset state
    @(posedge clk);
    reset_state();
    full_word_round_trip();
    narrow_writes();
    address_wrap();
    back_to_back_mix();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: common/mem_msg_if.sv
// memory message bus between the wishbone bridge and a client
// command flows bridge to client, response flows client to bridge
`timescale 1ns/10ps
`include "wb_bridge_cfg.svh"

interface mem_msg_if;

  // command channel
  mem_msg_pkg::mem_header_s  cmd_header;
  logic [`WB_DATA_WIDTH-1:0] cmd_data;
  logic                      cmd_v;
  logic                      cmd_ready_and;
  logic                      cmd_last;

  // response channel
  mem_msg_pkg::mem_header_s  resp_header;
  logic [`WB_DATA_WIDTH-1:0] resp_data;
  logic                      resp_v;
  logic                      resp_ready_and;
  logic                      resp_last;

  modport bridge (
    output cmd_header, cmd_data, cmd_v, cmd_last,
    input  cmd_ready_and,
    input  resp_header, resp_data, resp_v, resp_last,
    output resp_ready_and
  );

  modport client (
    input  cmd_header, cmd_data, cmd_v, cmd_last,
    output cmd_ready_and,
    output resp_header, resp_data, resp_v, resp_last,
    input  resp_ready_and
  );

endinterface

// File: common/mem_msg_pkg.sv
// types of the ready/valid memory message bus
// message type and size encodings plus the single-beat header layout
`include "wb_bridge_cfg.svh"

package mem_msg_pkg;

  // uncached opcodes only
  typedef enum logic {
    e_msg_uc_rd = 1'b0,
    e_msg_uc_wr = 1'b1
  } msg_type_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {
    e_msg_size_1 = 2'd0,
    e_msg_size_2 = 2'd1,
    e_msg_size_4 = 2'd2,
    e_msg_size_8 = 2'd3
  } msg_size_e;

  typedef struct packed {
    logic [`WB_PADDR_WIDTH-1:0]   addr;
    msg_size_e                    size;
    msg_type_e                    msg_type;
    logic [`MSG_SRC_ID_WIDTH-1:0] src_id;
  } mem_header_s;

endpackage

// File: common/wb_bridge_cfg.svh
// build-time configuration for the wishbone to memory message bridge
// include wherever a bus width, memory size or header constant is needed
`ifndef WB_BRIDGE_CFG_SVH
`define WB_BRIDGE_CFG_SVH

// bus data width and its byte count
`define WB_DATA_WIDTH 64
`define WB_SEL_WIDTH (`WB_DATA_WIDTH / 8)

// byte address and word address widths
`define WB_PADDR_WIDTH 12
`define WB_ADDR_WIDTH (`WB_PADDR_WIDTH - 3)

// client memory
`define MEM_WORDS 16
`define MEM_RESP_LATENCY 2

// requester id written into every command header
`define MSG_SRC_ID_WIDTH 4
`define MSG_SRC_ID 4'd5

`endif

// File: common/wb_pkg.sv
// wishbone side types shared by the bridge and the subsystem top
// widths follow the configuration header
`include "wb_bridge_cfg.svh"

package wb_pkg;

  // one bit per data byte
  typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;

  // word address, byte offset bits are not carried on the bus
  typedef logic [`WB_ADDR_WIDTH-1:0] wb_adr_t;

  typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

// File: hdl/mem_client_ram.sv
// memory message bus client backed by a small word memory
// one command in flight, answered after a fixed latency with the header echoed
`timescale 1ns/10ps
`include "wb_bridge_cfg.svh"

module mem_client_ram (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_msg_if.client msg
);

  localparam int IDX_W    = $clog2(`MEM_WORDS);
  localparam int LAT_W    = $clog2(`MEM_RESP_LATENCY + 1);
  localparam int BYTE_OFS = `WB_PADDR_WIDTH - `WB_ADDR_WIDTH;

  logic [`WB_DATA_WIDTH-1:0] mem_q [`MEM_WORDS];
  logic [IDX_W-1:0]          cmd_idx;
  logic [`WB_DATA_WIDTH-1:0] wr_mask;
  logic [`WB_DATA_WIDTH-1:0] wr_word;
  logic                      cmd_fire;
  logic                      resp_fire;
  logic                      resp_v;
  logic                      pending_q;
  logic [LAT_W-1:0]          lat_cnt_q;
  mem_msg_pkg::mem_header_s  resp_header_q;
  logic [`WB_DATA_WIDTH-1:0] resp_data_q;

  // word index wraps modulo the memory depth
  assign cmd_idx = msg.cmd_header.addr[BYTE_OFS +: IDX_W];

  assign cmd_fire  = msg.cmd_v && !pending_q;
  assign resp_v    = pending_q && (lat_cnt_q == '0);
  assign resp_fire = resp_v && msg.resp_ready_and;

  // keep the low 2^size bytes of the command data
  always_comb begin
    wr_mask = '0;
    for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
      if (b < (1 << int'(msg.cmd_header.size))) begin
        wr_mask[8*b +: 8] = 8'hff;
      end
    end
    wr_word = (mem_q[cmd_idx] & ~wr_mask) | (msg.cmd_data & wr_mask);
  end

  // pending flag and latency count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      lat_cnt_q <= '0;
    end else if (cmd_fire) begin
      pending_q <= 1'b1;
      lat_cnt_q <= LAT_W'(`MEM_RESP_LATENCY - 1);
    end else if (resp_fire) begin
      pending_q <= 1'b0;
    end else if (pending_q && (lat_cnt_q != '0)) begin
      lat_cnt_q <= lat_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < `MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (cmd_fire && (msg.cmd_header.msg_type == mem_msg_pkg::e_msg_uc_wr)) begin
      mem_q[cmd_idx] <= wr_word;
    end
  end

  // response payload, a write answers with the previous word
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_header_q <= msg.cmd_header;
      resp_data_q   <= mem_q[cmd_idx];
    end
  end

  assign msg.cmd_ready_and = !pending_q;
  assign msg.resp_v        = resp_v;
  assign msg.resp_header   = resp_header_q;
  assign msg.resp_data     = resp_data_q;
  assign msg.resp_last     = 1'b1;

endmodule

// File: hdl/wb_mem_subsys.sv
// wishbone slave subsystem with a message bus client memory behind it
// plain wishbone ports, the message bus stays internal
`timescale 1ns/10ps

module wb_mem_subsys (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_pkg::wb_adr_t  wb_adr_i,
  input  wb_pkg::wb_data_t wb_dat_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  wb_pkg::wb_sel_t  wb_sel_i,
  input  logic             wb_we_i,
  output wb_pkg::wb_data_t wb_dat_o,
  output logic             wb_ack_o
);

  // command and response channels
  mem_msg_if msg_if ();

  wb_client_bridge wb_client_bridge_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .msg      (msg_if.bridge)
  );

  mem_client_ram mem_client_ram_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .msg      (msg_if.client)
  );

endmodule

// File: wb_client/wb_client_bridge.sv
// wishbone b4 classic slave that issues one uncached message per access
// writes ack when the command is taken, reads ack on the read response
// narrow write data is replicated across the whole bus word
`timescale 1ns/10ps
`include "wb_bridge_cfg.svh"

module wb_client_bridge (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  wb_pkg::wb_adr_t  wb_adr_i,
  input  wb_pkg::wb_data_t wb_dat_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  input  logic             wb_we_i,
  input  wb_pkg::wb_sel_t  wb_sel_i,
  output wb_pkg::wb_data_t wb_dat_o,
  output logic             wb_ack_o,
  mem_msg_if.bridge        msg
);

  localparam int BYTE_OFS = `WB_PADDR_WIDTH - `WB_ADDR_WIDTH;

  typedef enum logic [1:0] {
    e_reset          = 2'b00,
    e_wait_cmd       = 2'b01,
    e_wait_read_resp = 2'b10
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  mem_msg_pkg::msg_size_e   cmd_size;
  mem_msg_pkg::mem_header_s cmd_header;
  wb_pkg::wb_data_t         cmd_data;
  logic                     cmd_v;
  logic                     ack;
  logic                     rd_resp;

  // select vector to access size, odd patterns count as a full word
  always_comb begin
    unique case (wb_sel_i)
      wb_pkg::wb_sel_t'(8'h01): cmd_size = mem_msg_pkg::e_msg_size_1;
      wb_pkg::wb_sel_t'(8'h03): cmd_size = mem_msg_pkg::e_msg_size_2;
      wb_pkg::wb_sel_t'(8'h0f): cmd_size = mem_msg_pkg::e_msg_size_4;
      default:                  cmd_size = mem_msg_pkg::e_msg_size_8;
    endcase
  end

  // replicate the low bytes at the access size
  always_comb begin
    unique case (cmd_size)
      mem_msg_pkg::e_msg_size_1: cmd_data = {(`WB_DATA_WIDTH / 8){wb_dat_i[7:0]}};
      mem_msg_pkg::e_msg_size_2: cmd_data = {(`WB_DATA_WIDTH / 16){wb_dat_i[15:0]}};
      mem_msg_pkg::e_msg_size_4: cmd_data = {(`WB_DATA_WIDTH / 32){wb_dat_i[31:0]}};
      default:                   cmd_data = wb_dat_i;
    endcase
  end

  assign cmd_header.addr     = {wb_adr_i, {BYTE_OFS{1'b0}}};
  assign cmd_header.size     = cmd_size;
  assign cmd_header.msg_type = wb_we_i ? mem_msg_pkg::e_msg_uc_wr : mem_msg_pkg::e_msg_uc_rd;
  assign cmd_header.src_id   = `MSG_SRC_ID;

  // only read responses complete a wishbone access
  assign rd_resp = msg.resp_v && (msg.resp_header.msg_type == mem_msg_pkg::e_msg_uc_rd);

  always_comb begin
    state_d = state_q;
    cmd_v   = 1'b0;
    ack     = 1'b0;
    unique case (state_q)
      e_reset: begin
        state_d = e_wait_cmd;
      end
      e_wait_cmd: begin
        cmd_v = wb_cyc_i && wb_stb_i;
        if (cmd_v && msg.cmd_ready_and) begin
          // a read may be answered in the same cycle
          if (wb_we_i || rd_resp) begin
            ack = 1'b1;
          end else begin
            state_d = e_wait_read_resp;
          end
        end
      end
      e_wait_read_resp: begin
        if (rd_resp) begin
          ack     = 1'b1;
          state_d = e_wait_cmd;
        end
      end
      default: begin
        state_d = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= e_reset;
    end else begin
      state_q <= state_d;
    end
  end

  assign msg.cmd_header     = cmd_header;
  assign msg.cmd_data       = cmd_data;
  assign msg.cmd_v          = cmd_v;
  assign msg.cmd_last       = 1'b1;
  // responses are never stalled
  assign msg.resp_ready_and = 1'b1;

  assign wb_dat_o = msg.resp_data;
  assign wb_ack_o = ack;

endmodule

// File: wb_mem_subsys.f
+incdir+common
common/mem_msg_pkg.sv
common/wb_pkg.sv
common/mem_msg_if.sv
wb_client/wb_client_bridge.sv
hdl/mem_client_ram.sv
hdl/wb_mem_subsys.sv
bench/tb_clk_gen.sv
bench/wb_mem_subsys_chk.sv
bench/wb_mem_subsys_tb.sv
